/* src/dbg_pkg.sv */
package dbg_pkg;

   // One debug ring flit.
   typedef logic [15:0] flit_t;

   // Ring node address. The debug interface is node 0 and the tiles follow it.
   typedef logic [3:0]  node_id_t;

   // Packet type as carried in the low nibble of a header flit.
   typedef logic [3:0]  pkt_type_t;

   typedef logic [31:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;

   localparam node_id_t IF_ID = 4'd0;

   localparam pkt_type_t TYPE_WRITE     = 4'd1;
   localparam pkt_type_t TYPE_READ      = 4'd2;
   localparam pkt_type_t TYPE_WRITE_ACK = 4'd3;
   localparam pkt_type_t TYPE_READ_RSP  = 4'd4;
   localparam pkt_type_t TYPE_ERR       = 4'd5;
   localparam pkt_type_t TYPE_CTRL      = 4'd6;

   // Header flit fields.
   localparam int DEST_MSB = 15;
   localparam int DEST_LSB = 12;
   localparam int SRC_MSB  = 11;
   localparam int SRC_LSB  = 8;
   localparam int SEL_MSB  = 7;
   localparam int SEL_LSB  = 4;
   localparam int TYPE_MSB = 3;
   localparam int TYPE_LSB = 0;

endpackage

/* src/dbg_ring_node.sv */
`timescale 1ns/1ps

module dbg_ring_node #(
   parameter dbg_pkg::node_id_t NODE_ID = 4'd1
) (
   input  logic           clk,
   input  logic           arst_n_i,

   input  dbg_pkg::flit_t ring_in_flit_i,
   input  logic           ring_in_last_i,
   input  logic           ring_in_valid_i,
   output logic           ring_in_ready_o,

   output dbg_pkg::flit_t ring_out_flit_o,
   output logic           ring_out_last_o,
   output logic           ring_out_valid_o,
   input  logic           ring_out_ready_i,

   output dbg_pkg::flit_t local_out_flit_o,
   output logic           local_out_last_o,
   output logic           local_out_valid_o,
   input  logic           local_out_ready_i,

   input  dbg_pkg::flit_t local_in_flit_i,
   input  logic           local_in_last_i,
   input  logic           local_in_valid_i,
   output logic           local_in_ready_o
);

   logic in_busy_q;
   logic route_q;
   logic out_lock_local_q;
   logic route_local;
   logic thru_busy;
   logic thru_sel;
   logic out_free;
   logic lo_free;
   logic in_xfer;
   logic inj_xfer;

   // The header decides the route, the flag keeps it until the last flit.
   assign route_local = in_busy_q ? route_q
                      : (ring_in_flit_i[dbg_pkg::DEST_MSB:dbg_pkg::DEST_LSB] == NODE_ID);
   assign thru_busy   = in_busy_q && !route_q;

   // Through traffic owns the output unless a local packet is already under way.
   assign thru_sel = !out_lock_local_q && (thru_busy || (ring_in_valid_i && !route_local));

   assign out_free = !ring_out_valid_o || ring_out_ready_i;
   assign lo_free  = !local_out_valid_o || local_out_ready_i;

   assign ring_in_ready_o  = route_local ? lo_free : (thru_sel && out_free);
   assign local_in_ready_o = !thru_sel && out_free;

   assign in_xfer  = ring_in_valid_i && ring_in_ready_o;
   assign inj_xfer = local_in_valid_i && local_in_ready_o;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_busy_q         <= 1'b0;
         route_q           <= 1'b0;
         out_lock_local_q  <= 1'b0;
         ring_out_valid_o  <= 1'b0;
         local_out_valid_o <= 1'b0;
      end else begin
         if (in_xfer) begin
            in_busy_q <= !ring_in_last_i;
            route_q   <= route_local;
         end
         if (inj_xfer) begin
            out_lock_local_q <= !local_in_last_i;
         end

         if ((in_xfer && !route_local) || inj_xfer) begin
            ring_out_valid_o <= 1'b1;
         end else if (ring_out_ready_i) begin
            ring_out_valid_o <= 1'b0;
         end

         if (in_xfer && route_local) begin
            local_out_valid_o <= 1'b1;
         end else if (local_out_ready_i) begin
            local_out_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_xfer && !route_local) begin
         ring_out_flit_o <= ring_in_flit_i;
         ring_out_last_o <= ring_in_last_i;
      end else if (inj_xfer) begin
         ring_out_flit_o <= local_in_flit_i;
         ring_out_last_o <= local_in_last_i;
      end
      if (in_xfer && route_local) begin
         local_out_flit_o <= ring_in_flit_i;
         local_out_last_o <= ring_in_last_i;
      end
   end

   a_no_local_in_thru: assert property (@(posedge clk) disable iff (!arst_n_i)
      inj_xfer |-> !thru_busy);

   a_out_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      ring_out_valid_o && !ring_out_ready_i |=> ring_out_valid_o && $stable(ring_out_flit_o));

endmodule

/* src/compute_tile_dm.sv */
`timescale 1ns/1ps

module compute_tile_dm #(
   parameter dbg_pkg::node_id_t TILE_ID = 4'd1
) (
   input  logic              clk,
   input  logic              arst_n_i,
   input  logic              sys_rst_i,

   input  dbg_pkg::flit_t    debug_ring_in_flit_i,
   input  logic              debug_ring_in_last_i,
   input  logic              debug_ring_in_valid_i,
   output logic              debug_ring_in_ready_o,

   output dbg_pkg::flit_t    debug_ring_out_flit_o,
   output logic              debug_ring_out_last_o,
   output logic              debug_ring_out_valid_o,
   input  logic              debug_ring_out_ready_i,

   output dbg_pkg::wb_adr_t  wb_adr_o,
   output dbg_pkg::wb_dat_t  wb_dat_o,
   output dbg_pkg::wb_sel_t  wb_sel_o,
   output logic              wb_we_o,
   output logic              wb_cyc_o,
   output logic              wb_stb_o,

   input  dbg_pkg::wb_dat_t  wb_dat_i,
   input  logic              wb_ack_i,
   input  logic              wb_err_i,
   input  logic              wb_rty_i
);

   typedef enum logic [2:0] {IDLE, COLLECT, BUS, RETRY, RESP} state_t;

   state_t              state_q;
   logic [2:0]          cnt_q;
   dbg_pkg::flit_t      hdr_q;
   dbg_pkg::wb_adr_t    adr_q;
   dbg_pkg::wb_dat_t    dat_q;
   dbg_pkg::pkt_type_t  rsp_type_q;

   dbg_pkg::flit_t      req_flit;
   logic                req_last;
   logic                req_valid;
   logic                req_ready;
   dbg_pkg::flit_t      rsp_flit;
   dbg_pkg::flit_t      rsp_hdr;
   logic                rsp_last;
   logic                rsp_valid;
   logic                rsp_ready;

   dbg_pkg::pkt_type_t  cur_type;
   logic [2:0]          cur_idx;
   logic                req_ok;
   logic                req_xfer;
   logic                rsp_xfer;

   dbg_ring_node #(
      .NODE_ID (TILE_ID)
   ) u_dbg_ring_node (
      .clk               (clk),
      .arst_n_i          (arst_n_i),
      .ring_in_flit_i    (debug_ring_in_flit_i),
      .ring_in_last_i    (debug_ring_in_last_i),
      .ring_in_valid_i   (debug_ring_in_valid_i),
      .ring_in_ready_o   (debug_ring_in_ready_o),
      .ring_out_flit_o   (debug_ring_out_flit_o),
      .ring_out_last_o   (debug_ring_out_last_o),
      .ring_out_valid_o  (debug_ring_out_valid_o),
      .ring_out_ready_i  (debug_ring_out_ready_i),
      .local_out_flit_o  (req_flit),
      .local_out_last_o  (req_last),
      .local_out_valid_o (req_valid),
      .local_out_ready_i (req_ready),
      .local_in_flit_i   (rsp_flit),
      .local_in_last_i   (rsp_last),
      .local_in_valid_i  (rsp_valid),
      .local_in_ready_o  (rsp_ready)
   );

   assign req_ready = (state_q == IDLE) || (state_q == COLLECT);
   assign req_xfer  = req_valid && req_ready;

   // In IDLE the incoming flit is the header itself.
   assign cur_type = (state_q == IDLE) ? req_flit[dbg_pkg::TYPE_MSB:dbg_pkg::TYPE_LSB]
                                       : hdr_q[dbg_pkg::TYPE_MSB:dbg_pkg::TYPE_LSB];
   assign cur_idx  = (state_q == IDLE) ? 3'd0 : cnt_q;

   // A request is only served when its type and length agree.
   assign req_ok = ((cur_type == dbg_pkg::TYPE_WRITE) && (cur_idx == 3'd4)) ||
                   ((cur_type == dbg_pkg::TYPE_READ) && (cur_idx == 3'd2));

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            IDLE, COLLECT: begin
               if (req_xfer) begin
                  if (req_last) begin
                     cnt_q   <= '0;
                     state_q <= (req_ok && !sys_rst_i) ? BUS : RESP;
                  end else begin
                     state_q <= COLLECT;
                     if (cur_idx != 3'd7) begin
                        cnt_q <= cur_idx + 3'd1;
                     end
                  end
               end
            end
            BUS: begin
               if (wb_ack_i || wb_err_i) begin
                  state_q <= RESP;
               end else if (wb_rty_i) begin
                  state_q <= RETRY;
               end
            end
            RETRY: state_q <= BUS;
            RESP: begin
               if (rsp_xfer) begin
                  if (rsp_last) begin
                     state_q <= IDLE;
                  end else begin
                     cnt_q <= cnt_q + 3'd1;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_xfer) begin
         case (cur_idx)
            3'd0: hdr_q <= req_flit;
            3'd1: adr_q[31:16] <= req_flit;
            3'd2: adr_q[15:0] <= req_flit;
            3'd3: dat_q[31:16] <= req_flit;
            3'd4: dat_q[15:0] <= req_flit;
            default: ;
         endcase
         // Anything that does not reach a successful bus answer reports an error.
         if (req_last) begin
            rsp_type_q <= dbg_pkg::TYPE_ERR;
         end
      end
      if ((state_q == BUS) && wb_ack_i) begin
         if (wb_we_o) begin
            rsp_type_q <= dbg_pkg::TYPE_WRITE_ACK;
         end else begin
            rsp_type_q <= dbg_pkg::TYPE_READ_RSP;
            dat_q      <= wb_dat_i;
         end
      end
   end

   assign wb_adr_o = adr_q;
   assign wb_dat_o = dat_q;
   assign wb_sel_o = hdr_q[dbg_pkg::SEL_MSB:dbg_pkg::SEL_LSB];
   assign wb_we_o  = (hdr_q[dbg_pkg::TYPE_MSB:dbg_pkg::TYPE_LSB] == dbg_pkg::TYPE_WRITE);
   assign wb_cyc_o = (state_q == BUS);
   assign wb_stb_o = (state_q == BUS);

   always_comb begin
      rsp_hdr = '0;
      rsp_hdr[dbg_pkg::DEST_MSB:dbg_pkg::DEST_LSB] = dbg_pkg::IF_ID;
      rsp_hdr[dbg_pkg::SRC_MSB:dbg_pkg::SRC_LSB]   = TILE_ID;
      rsp_hdr[dbg_pkg::SEL_MSB:dbg_pkg::SEL_LSB]   = hdr_q[dbg_pkg::SEL_MSB:dbg_pkg::SEL_LSB];
      rsp_hdr[dbg_pkg::TYPE_MSB:dbg_pkg::TYPE_LSB] = rsp_type_q;
   end

   assign rsp_valid = (state_q == RESP);
   assign rsp_flit  = (cnt_q == 3'd0) ? rsp_hdr
                    : (cnt_q == 3'd1) ? dat_q[31:16] : dat_q[15:0];
   assign rsp_last  = (rsp_type_q != dbg_pkg::TYPE_READ_RSP) || (cnt_q == 3'd2);
   assign rsp_xfer  = rsp_valid && rsp_ready;

   // The master holds its whole request until the slave answers.
   a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_cyc_o && wb_stb_o && !(wb_ack_i || wb_err_i || wb_rty_i) |=>
         wb_cyc_o && wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o) &&
         $stable(wb_sel_o) && $stable(wb_we_o));

endmodule

/* src/debug_interface.sv */
`timescale 1ns/1ps

module debug_interface (
   input  logic           clk,
   input  logic           arst_n_i,

   input  dbg_pkg::flit_t host_in_flit_i,
   input  logic           host_in_last_i,
   input  logic           host_in_valid_i,
   output logic           host_in_ready_o,

   output dbg_pkg::flit_t host_out_flit_o,
   output logic           host_out_last_o,
   output logic           host_out_valid_o,
   input  logic           host_out_ready_i,

   output dbg_pkg::flit_t ring_out_flit_o,
   output logic           ring_out_last_o,
   output logic           ring_out_valid_o,
   input  logic           ring_out_ready_i,

   input  dbg_pkg::flit_t ring_in_flit_i,
   input  logic           ring_in_last_i,
   input  logic           ring_in_valid_i,
   output logic           ring_in_ready_o,

   output logic           sys_rst_o,
   output logic           cpu_rst_o
);

   logic h_busy_q;
   logic h_ctrl_q;
   logic h_pay_q;
   logic r_busy_q;
   logic r_keep_q;
   logic is_ctrl;
   logic keep;
   logic h_xfer;
   logic r_xfer;

   // Control packets stop here and never reach the ring.
   assign is_ctrl = h_busy_q ? h_ctrl_q
                  : ((host_in_flit_i[dbg_pkg::DEST_MSB:dbg_pkg::DEST_LSB] == dbg_pkg::IF_ID) &&
                     (host_in_flit_i[dbg_pkg::TYPE_MSB:dbg_pkg::TYPE_LSB] == dbg_pkg::TYPE_CTRL));

   // Returning packets for other ids are drained.
   assign keep = r_busy_q ? r_keep_q
               : (ring_in_flit_i[dbg_pkg::DEST_MSB:dbg_pkg::DEST_LSB] == dbg_pkg::IF_ID);

   assign host_in_ready_o = is_ctrl || !ring_out_valid_o || ring_out_ready_i;
   assign ring_in_ready_o = !keep || !host_out_valid_o || host_out_ready_i;

   assign h_xfer = host_in_valid_i && host_in_ready_o;
   assign r_xfer = ring_in_valid_i && ring_in_ready_o;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         h_busy_q         <= 1'b0;
         h_ctrl_q         <= 1'b0;
         h_pay_q          <= 1'b0;
         r_busy_q         <= 1'b0;
         r_keep_q         <= 1'b0;
         ring_out_valid_o <= 1'b0;
         host_out_valid_o <= 1'b0;
         sys_rst_o        <= 1'b0;
         cpu_rst_o        <= 1'b0;
      end else begin
         if (h_xfer) begin
            h_busy_q <= !host_in_last_i;
            h_ctrl_q <= is_ctrl;
            h_pay_q  <= is_ctrl && !h_busy_q && !host_in_last_i;
            // The flit right after a control header holds the reset levels.
            if (h_pay_q) begin
               sys_rst_o <= host_in_flit_i[0];
               cpu_rst_o <= host_in_flit_i[1];
            end
         end
         if (r_xfer) begin
            r_busy_q <= !ring_in_last_i;
            r_keep_q <= keep;
         end

         if (h_xfer && !is_ctrl) begin
            ring_out_valid_o <= 1'b1;
         end else if (ring_out_ready_i) begin
            ring_out_valid_o <= 1'b0;
         end

         if (r_xfer && keep) begin
            host_out_valid_o <= 1'b1;
         end else if (host_out_ready_i) begin
            host_out_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (h_xfer && !is_ctrl) begin
         ring_out_flit_o <= host_in_flit_i;
         ring_out_last_o <= host_in_last_i;
      end
      if (r_xfer && keep) begin
         host_out_flit_o <= ring_in_flit_i;
         host_out_last_o <= ring_in_last_i;
      end
   end

endmodule

/* src/system_2x2_dm.sv */
`timescale 1ns/1ps

module system_2x2_dm (
   input  logic             clk,
   input  logic             arst_n_i,

   input  dbg_pkg::flit_t   host_in_flit_i,
   input  logic             host_in_last_i,
   input  logic             host_in_valid_i,
   output logic             host_in_ready_o,

   output dbg_pkg::flit_t   host_out_flit_o,
   output logic             host_out_last_o,
   output logic             host_out_valid_o,
   input  logic             host_out_ready_i,

   output logic             cpu_rst_o,

   output logic [4*32-1:0]  wb_ext_adr_o,
   output logic [4*32-1:0]  wb_ext_dat_o,
   output logic [4*4-1:0]   wb_ext_sel_o,
   output logic [4*1-1:0]   wb_ext_we_o,
   output logic [4*1-1:0]   wb_ext_cyc_o,
   output logic [4*1-1:0]   wb_ext_stb_o,
   input  logic [4*32-1:0]  wb_ext_dat_i,
   input  logic [4*1-1:0]   wb_ext_ack_i,
   input  logic [4*1-1:0]   wb_ext_err_i,
   input  logic [4*1-1:0]   wb_ext_rty_i
);

   dbg_pkg::flit_t ring_in_flit   [0:3];
   logic           ring_in_last   [0:3];
   logic           ring_in_valid  [0:3];
   logic           ring_in_ready  [0:3];
   dbg_pkg::flit_t ring_out_flit  [0:3];
   logic           ring_out_last  [0:3];
   logic           ring_out_valid [0:3];
   logic           ring_out_ready [0:3];

   logic           sys_rst;

   debug_interface u_debug_interface (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .host_in_flit_i   (host_in_flit_i),
      .host_in_last_i   (host_in_last_i),
      .host_in_valid_i  (host_in_valid_i),
      .host_in_ready_o  (host_in_ready_o),
      .host_out_flit_o  (host_out_flit_o),
      .host_out_last_o  (host_out_last_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i),
      .ring_out_flit_o  (ring_in_flit[0]),
      .ring_out_last_o  (ring_in_last[0]),
      .ring_out_valid_o (ring_in_valid[0]),
      .ring_out_ready_i (ring_in_ready[0]),
      .ring_in_flit_i   (ring_out_flit[2]),
      .ring_in_last_i   (ring_out_last[2]),
      .ring_in_valid_i  (ring_out_valid[2]),
      .ring_in_ready_o  (ring_out_ready[2]),
      .sys_rst_o        (sys_rst),
      .cpu_rst_o        (cpu_rst_o)
   );

   // The ring runs as a meander: tile 1, tile 2, tile 4, tile 3, back to the interface.
   assign ring_in_flit[1]   = ring_out_flit[0];
   assign ring_in_last[1]   = ring_out_last[0];
   assign ring_in_valid[1]  = ring_out_valid[0];
   assign ring_out_ready[0] = ring_in_ready[1];

   assign ring_in_flit[3]   = ring_out_flit[1];
   assign ring_in_last[3]   = ring_out_last[1];
   assign ring_in_valid[3]  = ring_out_valid[1];
   assign ring_out_ready[1] = ring_in_ready[3];

   assign ring_in_flit[2]   = ring_out_flit[3];
   assign ring_in_last[2]   = ring_out_last[3];
   assign ring_in_valid[2]  = ring_out_valid[3];
   assign ring_out_ready[3] = ring_in_ready[2];

   for (genvar i = 0; i < 4; i++) begin : gen_ct
      compute_tile_dm #(
         .TILE_ID (dbg_pkg::node_id_t'(i + 1))
      ) u_ct (
         .clk                    (clk),
         .arst_n_i               (arst_n_i),
         .sys_rst_i              (sys_rst),
         .debug_ring_in_flit_i   (ring_in_flit[i]),
         .debug_ring_in_last_i   (ring_in_last[i]),
         .debug_ring_in_valid_i  (ring_in_valid[i]),
         .debug_ring_in_ready_o  (ring_in_ready[i]),
         .debug_ring_out_flit_o  (ring_out_flit[i]),
         .debug_ring_out_last_o  (ring_out_last[i]),
         .debug_ring_out_valid_o (ring_out_valid[i]),
         .debug_ring_out_ready_i (ring_out_ready[i]),
         .wb_adr_o               (wb_ext_adr_o[i*32 +: 32]),
         .wb_dat_o               (wb_ext_dat_o[i*32 +: 32]),
         .wb_sel_o               (wb_ext_sel_o[i*4 +: 4]),
         .wb_we_o                (wb_ext_we_o[i]),
         .wb_cyc_o               (wb_ext_cyc_o[i]),
         .wb_stb_o               (wb_ext_stb_o[i]),
         .wb_dat_i               (wb_ext_dat_i[i*32 +: 32]),
         .wb_ack_i               (wb_ext_ack_i[i]),
         .wb_err_i               (wb_ext_err_i[i]),
         .wb_rty_i               (wb_ext_rty_i[i])
      );
   end

endmodule

/* tb/tb_wb_mem.sv */
`timescale 1ns/1ps

module tb_wb_mem #(
   parameter int          TILE    = 1,
   parameter logic [31:0] ERR_ADR = 32'h0000_0380,
   parameter logic [31:0] RTY_ADR = 32'h0000_0200,
   parameter int          RTY_CNT = 3
) (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o,
   output logic        rty_o
);

   logic [31:0] mem [0:255];
   int          rty_left;
   logic        req;

   // Power-up contents depend on the tile and on the word address.
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {16'hc3c3 ^ 16'(TILE), 6'd0, 8'(i), 2'b00};
      end
   end

   // A new answer is only given once the previous one has been seen by the master.
   assign req = cyc_i && stb_i && !ack_o && !err_o && !rty_o;

   always @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o    <= 1'b0;
         err_o    <= 1'b0;
         rty_o    <= 1'b0;
         dat_o    <= '0;
         rty_left <= RTY_CNT;
      end else begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         rty_o <= 1'b0;
         if (req) begin
            if (adr_i == ERR_ADR) begin
               err_o <= 1'b1;
            end else if ((adr_i == RTY_ADR) && (rty_left != 0)) begin
               rty_o    <= 1'b1;
               rty_left <= rty_left - 1;
            end else begin
               // Reads always return the whole word.
               ack_o    <= 1'b1;
               rty_left <= RTY_CNT;
               dat_o    <= mem[adr_i[9:2]];
               if (we_i) begin
                  for (int b = 0; b < 4; b++) begin
                     if (sel_i[b]) begin
                        mem[adr_i[9:2]][8*b +: 8] <= dat_i[8*b +: 8];
                     end
                  end
               end
            end
         end
      end
   end

endmodule

/* tb/tb_system_2x2_dm.sv */
`timescale 1ns/1ps

module tb_system_2x2_dm;

   logic            clk;
   logic            arst_n_i;
   dbg_pkg::flit_t  host_in_flit_i;
   logic            host_in_last_i;
   logic            host_in_valid_i;
   logic            host_in_ready_o;
   dbg_pkg::flit_t  host_out_flit_o;
   logic            host_out_last_o;
   logic            host_out_valid_o;
   logic            host_out_ready_i;
   logic            cpu_rst_o;
   logic [127:0]    wb_ext_adr_o;
   logic [127:0]    wb_ext_dat_o;
   logic [15:0]     wb_ext_sel_o;
   logic [3:0]      wb_ext_we_o;
   logic [3:0]      wb_ext_cyc_o;
   logic [3:0]      wb_ext_stb_o;
   logic [127:0]    wb_ext_dat_i;
   logic [3:0]      wb_ext_ack_i;
   logic [3:0]      wb_ext_err_i;
   logic [3:0]      wb_ext_rty_i;

   integer          seed;
   int              errors;
   int              cycles;
   int              sent;
   int              pending;
   int              rx_len;
   logic            rand_ready;
   logic            no_cyc_chk;
   logic            sys_rst_exp;
   dbg_pkg::flit_t  tx_buf [0:4];
   dbg_pkg::flit_t  rx_buf [0:2];
   logic [31:0]     shadow [0:3][0:255];
   // A response is {flit count, header, first data flit, second data flit}.
   logic [49:0]     exp_q [0:3][$];
   logic [49:0]     rx_q [$];

   function automatic logic [31:0] err_adr(input int t);
      return 32'h0000_0380 + 32'(4 * t);
   endfunction

   function automatic logic [31:0] rty_adr(input int t);
      return 32'h0000_0200 + 32'(16 * t);
   endfunction

   system_2x2_dm u_system_2x2_dm (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .host_in_flit_i   (host_in_flit_i),
      .host_in_last_i   (host_in_last_i),
      .host_in_valid_i  (host_in_valid_i),
      .host_in_ready_o  (host_in_ready_o),
      .host_out_flit_o  (host_out_flit_o),
      .host_out_last_o  (host_out_last_o),
      .host_out_valid_o (host_out_valid_o),
      .host_out_ready_i (host_out_ready_i),
      .cpu_rst_o        (cpu_rst_o),
      .wb_ext_adr_o     (wb_ext_adr_o),
      .wb_ext_dat_o     (wb_ext_dat_o),
      .wb_ext_sel_o     (wb_ext_sel_o),
      .wb_ext_we_o      (wb_ext_we_o),
      .wb_ext_cyc_o     (wb_ext_cyc_o),
      .wb_ext_stb_o     (wb_ext_stb_o),
      .wb_ext_dat_i     (wb_ext_dat_i),
      .wb_ext_ack_i     (wb_ext_ack_i),
      .wb_ext_err_i     (wb_ext_err_i),
      .wb_ext_rty_i     (wb_ext_rty_i)
   );

   for (genvar i = 0; i < 4; i++) begin : gen_mem
      tb_wb_mem #(
         .TILE    (i + 1),
         .ERR_ADR (err_adr(i)),
         .RTY_ADR (rty_adr(i)),
         .RTY_CNT (3)
      ) u_mem (
         .clk      (clk),
         .arst_n_i (arst_n_i),
         .cyc_i    (wb_ext_cyc_o[i]),
         .stb_i    (wb_ext_stb_o[i]),
         .we_i     (wb_ext_we_o[i]),
         .adr_i    (wb_ext_adr_o[i*32 +: 32]),
         .dat_i    (wb_ext_dat_o[i*32 +: 32]),
         .sel_i    (wb_ext_sel_o[i*4 +: 4]),
         .dat_o    (wb_ext_dat_i[i*32 +: 32]),
         .ack_o    (wb_ext_ack_i[i]),
         .err_o    (wb_ext_err_i[i]),
         .rty_o    (wb_ext_rty_i[i])
      );
   end

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Expected response of tile t; a completed write also updates the shadow memory.
   function automatic logic [49:0] ref_response(input int t, input dbg_pkg::pkt_type_t typ,
                                                input logic [3:0] sel, input logic [31:0] adr,
                                                input logic [31:0] dat);
      dbg_pkg::flit_t hdr;
      logic [31:0]    word;
      hdr = {4'd0, 4'(t + 1), sel, dbg_pkg::TYPE_ERR};
      if (sys_rst_exp || (adr == err_adr(t)) ||
          ((typ != dbg_pkg::TYPE_WRITE) && (typ != dbg_pkg::TYPE_READ))) begin
         return {2'd1, hdr, 32'h0};
      end
      word = shadow[t][adr[9:2]];
      if (typ == dbg_pkg::TYPE_WRITE) begin
         for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
               word[8*b +: 8] = dat[8*b +: 8];
            end
         end
         shadow[t][adr[9:2]] = word;
         hdr[3:0] = dbg_pkg::TYPE_WRITE_ACK;
         return {2'd1, hdr, 32'h0};
      end
      hdr[3:0] = dbg_pkg::TYPE_READ_RSP;
      return {2'd3, hdr, word};
   endfunction

   task automatic send_packet(input int len);
      for (int i = 0; i < len; i++) begin
         @(negedge clk);
         host_in_flit_i  = tx_buf[i];
         host_in_last_i  = (i == len - 1);
         host_in_valid_i = 1'b1;
         #1;
         while (!host_in_ready_o) begin
            @(negedge clk);
            #1;
         end
         @(posedge clk);
      end
      @(negedge clk);
      host_in_valid_i = 1'b0;
      sent++;
   endtask

   // Destination ids above 4 address no node, so no response is expected.
   task automatic request(input int t, input dbg_pkg::pkt_type_t typ, input logic [3:0] sel,
                          input logic [31:0] adr, input logic [31:0] dat);
      tx_buf[0] = {4'(t + 1), dbg_pkg::IF_ID, sel, typ};
      tx_buf[1] = adr[31:16];
      tx_buf[2] = adr[15:0];
      tx_buf[3] = dat[31:16];
      tx_buf[4] = dat[15:0];
      if (t < 4) begin
         exp_q[t].push_back(ref_response(t, typ, sel, adr, dat));
         pending++;
      end
      send_packet((typ == dbg_pkg::TYPE_WRITE) ? 5 : 3);
   endtask

   task automatic set_resets(input logic sys, input logic cpu);
      tx_buf[0] = {dbg_pkg::IF_ID, 4'd0, 4'd0, dbg_pkg::TYPE_CTRL};
      tx_buf[1] = {14'd0, cpu, sys};
      send_packet(2);
      sys_rst_exp = sys;
      assert (cpu_rst_o === cpu) else begin
         errors++;
         $display("Error cpu_rst_o exp %h got %h", cpu, cpu_rst_o);
      end
   endtask

   task automatic wait_idle();
      while (pending != 0) begin
         @(posedge clk);
      end
   endtask

   // Collects host_out packets; ready changes on the falling edge.
   always @(negedge clk) begin
      if (rand_ready) begin
         host_out_ready_i = (($random(seed) & 3) != 0);
      end else begin
         host_out_ready_i = 1'b1;
      end
      #1;
      if (host_out_valid_o && host_out_ready_i) begin
         if (rx_len < 3) begin
            rx_buf[rx_len] = host_out_flit_o;
         end
         rx_len++;
         if (host_out_last_o) begin
            if (rx_len > 3) begin
               errors++;
               $display("Response packet of %0d flits is longer than any response", rx_len);
            end else begin
               rx_q.push_back({2'(rx_len), rx_buf[0], rx_buf[1], rx_buf[2]});
            end
            rx_len = 0;
         end
      end
   end

   // Responses are matched per source tile, in request order.
   always @(posedge clk) begin
      logic [49:0] got;
      logic [49:0] exp;
      int          t;
      if (rx_q.size() != 0) begin
         got = rx_q.pop_front();
         t = int'(got[43:40]) - 1;
         if ((t < 0) || (t > 3) || (exp_q[t].size() == 0)) begin
            errors++;
            $display("Unexpected response packet with header %h", got[47:32]);
         end else begin
            exp = exp_q[t].pop_front();
            pending--;
            assert (got[49:48] == exp[49:48]) else begin
               errors++;
               $display("Error response length exp %h got %h", exp[49:48], got[49:48]);
            end
            for (int i = 0; i < int'(exp[49:48]); i++) begin
               assert (got[47-16*i -: 16] == exp[47-16*i -: 16]) else begin
                  errors++;
                  $display("Error host_out_flit exp %h got %h",
                           exp[47-16*i -: 16], got[47-16*i -: 16]);
               end
            end
         end
      end
   end

   // Classic cycles raise cyc and stb together.
   // No tile may start a bus cycle while the system reset is set.
   always @(negedge clk) begin
      assert (wb_ext_stb_o == wb_ext_cyc_o) else begin
         errors++;
         $display("Error wb_ext_stb_o exp %h got %h", wb_ext_cyc_o, wb_ext_stb_o);
      end
      if (no_cyc_chk) begin
         assert (wb_ext_cyc_o == 4'h0) else begin
            errors++;
            $display("Error wb_ext_cyc_o exp %h got %h", 4'h0, wb_ext_cyc_o);
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles <= 1000 + 200 * sent) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, %0d responses missing, %0d errors",
               cycles, pending, errors);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      seed             = 32'h89c1_3256;
      errors           = 0;
      rx_len           = 0;
      rand_ready       = 1'b0;
      no_cyc_chk       = 1'b0;
      sys_rst_exp      = 1'b0;
      arst_n_i         = 1'b0;
      host_in_flit_i   = '0;
      host_in_last_i   = 1'b0;
      host_in_valid_i  = 1'b0;
      host_out_ready_i = 1'b1;
      for (int t = 0; t < 4; t++) begin
         for (int i = 0; i < 256; i++) begin
            shadow[t][i] = {16'hc3c3 ^ 16'(t + 1), 6'd0, 8'(i), 2'b00};
         end
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n_i = 1'b1;

      // Full and partial writes to each tile, each read back.
      for (int t = 0; t < 4; t++) begin
         request(t, dbg_pkg::TYPE_WRITE, 4'hf, 32'h10 + 32'(4 * t), 32'hdead_0000 + 32'(t));
         request(t, dbg_pkg::TYPE_READ, 4'hf, 32'h10 + 32'(4 * t), 32'h0);
         request(t, dbg_pkg::TYPE_WRITE, 4'h5, 32'h40, 32'h1122_3344);
         request(t, dbg_pkg::TYPE_READ, 4'hf, 32'h40, 32'h0);
      end
      wait_idle();

      // Scripted err and rty addresses.
      for (int t = 0; t < 4; t++) begin
         request(t, dbg_pkg::TYPE_WRITE, 4'hf, err_adr(t), 32'h5555_aaaa);
         request(t, dbg_pkg::TYPE_READ, 4'hf, err_adr(t), 32'h0);
         request(t, dbg_pkg::TYPE_WRITE, 4'hf, rty_adr(t), 32'h0bad_f00d ^ 32'(t));
         request(t, dbg_pkg::TYPE_READ, 4'hf, rty_adr(t), 32'h0);
      end
      wait_idle();

      // Packets to unused ids, then a normal request.
      request(6, dbg_pkg::TYPE_READ, 4'hf, 32'h10, 32'h0);
      request(14, dbg_pkg::TYPE_WRITE, 4'hf, 32'h14, 32'h1234_5678);
      request(1, dbg_pkg::TYPE_READ, 4'hf, 32'h14, 32'h0);
      wait_idle();

      // The CPU reset alone leaves the tiles serving requests.
      set_resets(1'b0, 1'b1);
      request(0, dbg_pkg::TYPE_READ, 4'hf, 32'h10, 32'h0);
      wait_idle();

      // System reset set, then cleared.
      set_resets(1'b1, 1'b1);
      no_cyc_chk = 1'b1;
      for (int t = 0; t < 4; t++) begin
         request(t, dbg_pkg::TYPE_WRITE, 4'hf, 32'h10 + 32'(4 * t), 32'hffff_ffff);
         request(t, dbg_pkg::TYPE_READ, 4'hf, 32'h10 + 32'(4 * t), 32'h0);
      end
      wait_idle();
      no_cyc_chk = 1'b0;
      set_resets(1'b0, 1'b0);
      for (int t = 0; t < 4; t++) begin
         request(t, dbg_pkg::TYPE_READ, 4'hf, 32'h10 + 32'(4 * t), 32'h0);
      end
      wait_idle();

      // Back-to-back traffic under random host back-pressure.
      rand_ready = 1'b1;
      for (int r = 0; r < 6; r++) begin
         for (int t = 0; t < 4; t++) begin
            request(t, dbg_pkg::TYPE_WRITE, 4'($random(seed)), 32'h80 + 32'(4 * r),
                    $random(seed));
            request(t, dbg_pkg::TYPE_READ, 4'hf, 32'h80 + 32'(4 * r), 32'h0);
         end
      end
      request(2, dbg_pkg::TYPE_READ, 4'hf, rty_adr(2), 32'h0);
      wait_idle();
      rand_ready = 1'b0;

      // Quiet time so that any stray packet still shows up.
      repeat (50) @(posedge clk);
      $display("Errors: %0d, responses missing: %0d", errors, pending);
      if ((errors == 0) && (pending == 0)) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
src/dbg_pkg.sv
src/dbg_ring_node.sv
src/compute_tile_dm.sv
src/debug_interface.sv
src/system_2x2_dm.sv
tb/tb_wb_mem.sv
tb/tb_system_2x2_dm.sv
